// ==== Makefile ====
VERILATOR := verilator
TOP       := game_top_tb
FILELIST  := compile.f
OBJ_DIR   := obj_dir
LOG       := sim.log
SIM       := $(OBJ_DIR)/V$(TOP)

# tiny raster for simulation, every macro of the params header is given
DEFINES := -DVGA_PARAMS_SVH \
           -DHOR_PIXELS=64 -DHOR_FRONT=4 -DHOR_SYNC=8 -DHOR_BACK=4 \
           -DVER_PIXELS=48 -DVER_FRONT=2 -DVER_SYNC=2 -DVER_BACK=2 \
           -DROUND_FRAMES=3 -DWIN_HITS=4 \
           "-DRGB_BLACK=12'h000" "-DRGB_TOP=12'hff0" "-DRGB_BOTTOM=12'hf00" \
           "-DRGB_LEFT=12'h0f0" "-DRGB_RIGHT=12'h00f" "-DRGB_WIN=12'h0f0" \
           "-DRGB_LOSE=12'hf00" "-DRGB_FILL=12'h88f"

VFLAGS := --binary --timing --timescale 1ns/1ps -j 0 --top-module $(TOP) \
          -Mdir $(OBJ_DIR) $(DEFINES)

SOURCES := $(shell grep -v '^+' $(FILELIST)) source/vga_params.svh

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST) Makefile
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "^Simulation PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== compile.f ====
+incdir+source
source/vga_pkg.sv
source/game_pkg.sv
source/vga_timing.sv
source/game_fsm.sv
source/draw_bg.sv
source/game_top.sv
verif/game_top_tb.sv

// ==== source/draw_bg.sv ====
// background painter
// one register stage on all raster signals
// colour priority is blank, top, bottom, left, right, then result fill

`timescale 1ns/1ps
`default_nettype none

`include "vga_params.svh"

module draw_bg (
    input  logic                   clk,
    input  logic                   rst,
    input  game_pkg::game_result_t result,
    input  vga_pkg::count_t        hcount_in,
    input  vga_pkg::count_t        vcount_in,
    input  logic                   hsync_in,
    input  logic                   vsync_in,
    input  logic                   hblnk_in,
    input  logic                   vblnk_in,
    output vga_pkg::count_t        hcount,
    output vga_pkg::count_t        vcount,
    output logic                   hsync,
    output logic                   vsync,
    output logic                   hblnk,
    output logic                   vblnk,
    output vga_pkg::rgb_t          rgb
);

    localparam vga_pkg::count_t H_LAST = vga_pkg::count_t'(`HOR_PIXELS - 1);
    localparam vga_pkg::count_t V_LAST = vga_pkg::count_t'(`VER_PIXELS - 1);

    vga_pkg::rgb_t rgb_nxt;

    always_comb begin
        if (hblnk_in || vblnk_in)
            rgb_nxt = `RGB_BLACK;                   // blanking
        else if (vcount_in == '0)
            rgb_nxt = `RGB_TOP;
        else if (vcount_in == V_LAST)
            rgb_nxt = `RGB_BOTTOM;
        else if (hcount_in == '0)
            rgb_nxt = `RGB_LEFT;
        else if (hcount_in == H_LAST)
            rgb_nxt = `RGB_RIGHT;
        else if (result == game_pkg::RES_WIN)
            rgb_nxt = `RGB_WIN;                     // inner area shows the outcome
        else if (result == game_pkg::RES_LOSE)
            rgb_nxt = `RGB_LOSE;
        else
            rgb_nxt = `RGB_FILL;                    // no result yet
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hcount <= '0;
            vcount <= '0;
            hsync  <= 1'b0;
            vsync  <= 1'b0;
            hblnk  <= 1'b0;
            vblnk  <= 1'b0;
            rgb    <= '0;
        end else begin
            hcount <= hcount_in;                    // keep timing aligned with rgb
            vcount <= vcount_in;
            hsync  <= hsync_in;
            vsync  <= vsync_in;
            hblnk  <= hblnk_in;
            vblnk  <= vblnk_in;
            rgb    <= rgb_nxt;
        end
    end

endmodule

`default_nettype wire

// ==== source/game_fsm.sv ====
// game control FSM
// start request latch, frame edge detect from vblnk
// frame counter, saturating hit counter, round result

`timescale 1ns/1ps
`default_nettype none

`include "vga_params.svh"

module game_fsm (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start,
    input  logic                     hit,
    input  logic                     vblnk,
    output game_pkg::game_state_t    state,
    output game_pkg::game_result_t   result
);

    localparam int FW = $clog2(`ROUND_FRAMES + 1);

    localparam logic [FW-1:0] FRAME_LAST = FW'(`ROUND_FRAMES - 1);
    localparam logic [3:0]    WIN_MIN    = 4'(`WIN_HITS);

    logic                   vblnk_d;        // vblnk one cycle back
    logic                   frame_edge;     // first cycle of an active frame
    logic                   start_pend;
    logic                   start_pend_nxt;
    logic [FW-1:0]          frame_cnt;
    logic [FW-1:0]          frame_cnt_nxt;
    logic [3:0]             hit_cnt;
    logic [3:0]             hit_cnt_nxt;
    game_pkg::game_state_t  state_nxt;
    game_pkg::game_result_t result_nxt;

    assign frame_edge = vblnk_d && !vblnk;  // falling edge of vertical blank

    always_comb begin
        state_nxt      = state;
        result_nxt     = result;
        start_pend_nxt = start_pend;
        frame_cnt_nxt  = frame_cnt;
        hit_cnt_nxt    = hit_cnt;
        case (state)
            game_pkg::ST_START, game_pkg::ST_END: begin
                if (start)
                    start_pend_nxt = 1'b1;              // hold request till the frame edge
                if (frame_edge && (start_pend || start)) begin
                    state_nxt      = game_pkg::ST_PLAY;
                    result_nxt     = game_pkg::RES_NONE;
                    start_pend_nxt = 1'b0;
                    frame_cnt_nxt  = '0;
                    hit_cnt_nxt    = '0;
                end
            end
            game_pkg::ST_PLAY: begin
                if (hit && (hit_cnt != 4'hf))
                    hit_cnt_nxt = hit_cnt + 1'b1;       // saturates at 15
                if (frame_edge) begin
                    if (frame_cnt == FRAME_LAST) begin  // round over
                        state_nxt  = game_pkg::ST_END;
                        result_nxt = (hit_cnt_nxt >= WIN_MIN) ? game_pkg::RES_WIN
                                                              : game_pkg::RES_LOSE;
                    end else begin
                        frame_cnt_nxt = frame_cnt + 1'b1;
                    end
                end
            end
            default: state_nxt = game_pkg::ST_START;   // unused code
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vblnk_d    <= 1'b0;
            state      <= game_pkg::ST_START;
            result     <= game_pkg::RES_NONE;
            start_pend <= 1'b0;
            frame_cnt  <= '0;
            hit_cnt    <= '0;
        end else begin
            vblnk_d    <= vblnk;
            state      <= state_nxt;
            result     <= result_nxt;
            start_pend <= start_pend_nxt;
            frame_cnt  <= frame_cnt_nxt;
            hit_cnt    <= hit_cnt_nxt;
        end
    end

endmodule

`default_nettype wire

// ==== source/game_pkg.sv ====
// game control types
//   game_state_t   FSM state
//   game_result_t  round outcome, painter encoding

`default_nettype none

package game_pkg;

    typedef enum logic [1:0] {
        ST_START,   // title screen, waiting for start
        ST_PLAY,    // round in progress
        ST_END      // result shown
    } game_state_t;

    typedef enum logic [1:0] {
        RES_NONE = 2'b00,
        RES_LOSE = 2'b01,
        RES_WIN  = 2'b10
    } game_result_t;

endpackage

`default_nettype wire

// ==== source/game_top.sv ====
// game screen top level
// raster timing -> background painter, game FSM drives the result
// one registered pixel stream out, FSM state and result exported

`timescale 1ns/1ps
`default_nettype none

module game_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,      // level request
    input  logic                   hit,        // one pulse per hit
    output vga_pkg::count_t        hcount,
    output vga_pkg::count_t        vcount,
    output logic                   hsync,
    output logic                   vsync,
    output logic                   hblnk,
    output logic                   vblnk,
    output vga_pkg::rgb_t          rgb,
    output game_pkg::game_state_t  state,
    output game_pkg::game_result_t result
);

    vga_pkg::count_t tim_hcount;    // raw raster from the counters
    vga_pkg::count_t tim_vcount;
    logic            tim_hsync;
    logic            tim_vsync;
    logic            tim_hblnk;
    logic            tim_vblnk;

    vga_timing vga_timing_i (
        .clk    (clk),
        .rst    (rst),
        .hcount (tim_hcount),
        .vcount (tim_vcount),
        .hsync  (tim_hsync),
        .vsync  (tim_vsync),
        .hblnk  (tim_hblnk),
        .vblnk  (tim_vblnk)
    );

    game_fsm game_fsm_i (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .hit    (hit),
        .vblnk  (tim_vblnk),      // frame edge source
        .state  (state),
        .result (result)
    );

    draw_bg draw_bg_i (
        .clk       (clk),
        .rst       (rst),
        .result    (result),
        .hcount_in (tim_hcount),
        .vcount_in (tim_vcount),
        .hsync_in  (tim_hsync),
        .vsync_in  (tim_vsync),
        .hblnk_in  (tim_hblnk),
        .vblnk_in  (tim_vblnk),
        .hcount    (hcount),
        .vcount    (vcount),
        .hsync     (hsync),
        .vsync     (vsync),
        .hblnk     (hblnk),
        .vblnk     (vblnk),
        .rgb       (rgb)
    );

endmodule

`default_nettype wire

// ==== source/vga_params.svh ====
// raster geometry for the VGA timing generator
// round length and win threshold for the game FSM
// 12-bit 4:4:4 colour constants for the background painter
// a build overrides the set by predefining the guard and every macro

`ifndef VGA_PARAMS_SVH
`define VGA_PARAMS_SVH

// horizontal, in pixels
`define HOR_PIXELS 800
`define HOR_FRONT  40
`define HOR_SYNC   128
`define HOR_BACK   88

// vertical, in lines
`define VER_PIXELS 600
`define VER_FRONT  1
`define VER_SYNC   4
`define VER_BACK   23

`define ROUND_FRAMES 3 // frames per round
`define WIN_HITS     4 // min hits for a win

`define RGB_BLACK  12'h000
`define RGB_TOP    12'hff0 // yellow
`define RGB_BOTTOM 12'hf00 // red
`define RGB_LEFT   12'h0f0 // green
`define RGB_RIGHT  12'h00f // blue
`define RGB_WIN    12'h0f0
`define RGB_LOSE   12'hf00
`define RGB_FILL   12'h88f // neutral grey-blue

`endif

// ==== source/vga_pkg.sv ====
// raster types shared by the timing generator, painter and top
//   count_t  pixel or line coordinate
//   rgb_t    4:4:4 colour word

`default_nettype none

package vga_pkg;

    // 11 bits covers totals up to 2047
    typedef logic [10:0] count_t;

    // r in [11:8], g in [7:4], b in [3:0]
    typedef logic [11:0] rgb_t;

endpackage

`default_nettype wire

// ==== source/vga_timing.sv ====
// VGA raster timing generator
// horizontal and vertical counters over the full totals
// registered sync and blanking decode aligned with the counters

`timescale 1ns/1ps
`default_nettype none

`include "vga_params.svh"

module vga_timing (
    input  logic            clk,
    input  logic            rst,
    output vga_pkg::count_t hcount,
    output vga_pkg::count_t vcount,
    output logic            hsync,
    output logic            vsync,
    output logic            hblnk,
    output logic            vblnk
);

    localparam int H_TOTAL = `HOR_PIXELS + `HOR_FRONT + `HOR_SYNC + `HOR_BACK;
    localparam int V_TOTAL = `VER_PIXELS + `VER_FRONT + `VER_SYNC + `VER_BACK;

    localparam vga_pkg::count_t H_LAST   = vga_pkg::count_t'(H_TOTAL - 1);
    localparam vga_pkg::count_t V_LAST   = vga_pkg::count_t'(V_TOTAL - 1);
    localparam vga_pkg::count_t H_ACTIVE = vga_pkg::count_t'(`HOR_PIXELS);
    localparam vga_pkg::count_t V_ACTIVE = vga_pkg::count_t'(`VER_PIXELS);
    localparam vga_pkg::count_t HS_START = vga_pkg::count_t'(`HOR_PIXELS + `HOR_FRONT);
    localparam vga_pkg::count_t HS_END   = vga_pkg::count_t'(`HOR_PIXELS + `HOR_FRONT
                                                             + `HOR_SYNC);
    localparam vga_pkg::count_t VS_START = vga_pkg::count_t'(`VER_PIXELS + `VER_FRONT);
    localparam vga_pkg::count_t VS_END   = vga_pkg::count_t'(`VER_PIXELS + `VER_FRONT
                                                             + `VER_SYNC);

    vga_pkg::count_t hcount_nxt;
    vga_pkg::count_t vcount_nxt;

    always_comb begin
        hcount_nxt = hcount + 1'b1;
        vcount_nxt = vcount;
        if (hcount == H_LAST) begin             // end of line
            hcount_nxt = '0;
            if (vcount == V_LAST)               // end of frame
                vcount_nxt = '0;
            else
                vcount_nxt = vcount + 1'b1;
        end
    end

    // decode from the next count so flags line up with the counters
    always_ff @(posedge clk) begin
        if (rst) begin
            hcount <= '0;
            vcount <= '0;
            hsync  <= 1'b0;
            vsync  <= 1'b0;
            hblnk  <= 1'b0;
            vblnk  <= 1'b0;
        end else begin
            hcount <= hcount_nxt;
            vcount <= vcount_nxt;
            hblnk  <= (hcount_nxt >= H_ACTIVE);
            vblnk  <= (vcount_nxt >= V_ACTIVE);
            hsync  <= (hcount_nxt >= HS_START) && (hcount_nxt < HS_END);   // pulse window
            vsync  <= (vcount_nxt >= VS_START) && (vcount_nxt < VS_END);
        end
    end

endmodule

`default_nettype wire

// ==== verif/game_top_tb.sv ====
// testbench for the VGA game screen top
// reference colour function, cycle model of the game FSM, raster checker
// start presses and LCG spaced hit pulses, cycle timeout

`timescale 1ns/1ps
`default_nettype none

`include "vga_params.svh"

module game_top_tb;

    localparam int H_TOTAL = `HOR_PIXELS + `HOR_FRONT + `HOR_SYNC + `HOR_BACK;
    localparam int V_TOTAL = `VER_PIXELS + `VER_FRONT + `VER_SYNC + `VER_BACK;
    localparam int TIMEOUT = 28 * H_TOTAL * V_TOTAL;     // about 11 frames of tests plus margin

    localparam vga_pkg::count_t H_LAST  = vga_pkg::count_t'(H_TOTAL - 1);
    localparam vga_pkg::count_t V_LAST  = vga_pkg::count_t'(V_TOTAL - 1);
    localparam vga_pkg::count_t H_ACT   = vga_pkg::count_t'(`HOR_PIXELS);
    localparam vga_pkg::count_t V_ACT   = vga_pkg::count_t'(`VER_PIXELS);
    localparam vga_pkg::count_t H_RIGHT = vga_pkg::count_t'(`HOR_PIXELS - 1);
    localparam vga_pkg::count_t V_BOT   = vga_pkg::count_t'(`VER_PIXELS - 1);
    localparam vga_pkg::count_t HS_LO   = vga_pkg::count_t'(`HOR_PIXELS + `HOR_FRONT);
    localparam vga_pkg::count_t HS_HI   = vga_pkg::count_t'(`HOR_PIXELS + `HOR_FRONT
                                                            + `HOR_SYNC);
    localparam vga_pkg::count_t VS_LO   = vga_pkg::count_t'(`VER_PIXELS + `VER_FRONT);
    localparam vga_pkg::count_t VS_HI   = vga_pkg::count_t'(`VER_PIXELS + `VER_FRONT
                                                            + `VER_SYNC);
    localparam vga_pkg::count_t H_MID   = vga_pkg::count_t'(`HOR_PIXELS / 2);
    localparam vga_pkg::count_t V_MID   = vga_pkg::count_t'(`VER_PIXELS / 2);

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   start;
    logic                   hit;
    vga_pkg::count_t        hcount;
    vga_pkg::count_t        vcount;
    logic                   hsync;
    logic                   vsync;
    logic                   hblnk;
    logic                   vblnk;
    vga_pkg::rgb_t          rgb;
    game_pkg::game_state_t  state;
    game_pkg::game_result_t result;

    logic                   rst_at_edge = 1'b1;     // rst as seen by the last rising edge
    logic                   started = 1'b0;
    vga_pkg::count_t        exp_h;
    vga_pkg::count_t        exp_v;
    logic                   exp_hs;
    logic                   exp_vs;
    logic                   exp_hb;
    logic                   exp_vb;
    vga_pkg::rgb_t          exp_rgb;
    game_pkg::game_state_t  exp_state;
    game_pkg::game_result_t exp_result;
    logic                   exp_pend;
    logic [3:0]             exp_hits;
    int                     exp_frames;
    int                     edge_count = 0;         // frame edges seen on the outputs
    int                     err_raster = 0;
    int                     err_rgb = 0;
    int                     err_state = 0;
    int                     err_flow = 0;
    int                     cycle_cnt = 0;
    logic [31:0]            lcg_state = 32'hec20b7c2;
    string                  test_name = "reset";

    game_top dut_i (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .hit    (hit),
        .hcount (hcount),
        .vcount (vcount),
        .hsync  (hsync),
        .vsync  (vsync),
        .hblnk  (hblnk),
        .vblnk  (vblnk),
        .rgb    (rgb),
        .state  (state),
        .result (result)
    );

    always #5 clk = ~clk;                           // 10 ns period

    always @(posedge clk) rst_at_edge <= rst;

    // border, blank and fill colours by priority
    function automatic vga_pkg::rgb_t ref_rgb(input vga_pkg::count_t h,
                                              input vga_pkg::count_t v,
                                              input logic hb,
                                              input logic vb,
                                              input game_pkg::game_result_t res);
        if (hb || vb)
            return `RGB_BLACK;
        if (v == '0)
            return `RGB_TOP;
        if (v == V_BOT)
            return `RGB_BOTTOM;
        if (h == '0)
            return `RGB_LEFT;
        if (h == H_RIGHT)
            return `RGB_RIGHT;
        case (res)
            game_pkg::RES_WIN:  return `RGB_WIN;
            game_pkg::RES_LOSE: return `RGB_LOSE;
            default:            return `RGB_FILL;
        endcase
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;    // numerical recipes constants
    endfunction

    // outputs sampled on the falling edge, model steps in the order the DUT does
    always @(negedge clk) begin
        if (rst_at_edge) begin
            if (hcount !== '0 || vcount !== '0 || {hsync, vsync, hblnk, vblnk} !== 4'b0
                || rgb !== '0) begin
                err_raster++;
                $display("[ERROR] %s reset outputs expected 0 actual %0d,%0d %b rgb=%h",
                         test_name, hcount, vcount, {hsync, vsync, hblnk, vblnk}, rgb);
            end
            exp_h      = '0;
            exp_v      = '0;
            started    = 1'b0;
            exp_state  = game_pkg::ST_START;
            exp_result = game_pkg::RES_NONE;
            exp_pend   = 1'b0;
            exp_hits   = '0;
            exp_frames = 0;
        end else begin
            exp_hb = (exp_h >= H_ACT);
            exp_vb = (exp_v >= V_ACT);
            exp_hs = (exp_h >= HS_LO) && (exp_h < HS_HI);
            exp_vs = (exp_v >= VS_LO) && (exp_v < VS_HI);
            if (hcount !== exp_h || vcount !== exp_v
                || {hsync, vsync, hblnk, vblnk} !== {exp_hs, exp_vs, exp_hb, exp_vb}) begin
                err_raster++;
                $display("[ERROR] %s raster expected %0d,%0d %b actual %0d,%0d %b", test_name,
                         exp_h, exp_v, {exp_hs, exp_vs, exp_hb, exp_vb},
                         hcount, vcount, {hsync, vsync, hblnk, vblnk});
            end
            exp_rgb = ref_rgb(exp_h, exp_v, exp_hb, exp_vb, exp_result); // last cycle's result
            if (rgb !== exp_rgb) begin
                err_rgb++;
                $display("[ERROR] %s rgb at %0d,%0d expected %h actual %h",
                         test_name, exp_h, exp_v, exp_rgb, rgb);
            end
            if (started && exp_h == '0 && exp_v == '0) begin   // frame edge seen
                edge_count++;
                if (exp_state != game_pkg::ST_PLAY) begin
                    if (exp_pend) begin
                        exp_state  = game_pkg::ST_PLAY;
                        exp_result = game_pkg::RES_NONE;
                        exp_pend   = 1'b0;
                        exp_hits   = '0;
                        exp_frames = 0;
                    end
                end else if (exp_frames == `ROUND_FRAMES - 1) begin
                    exp_state  = game_pkg::ST_END;
                    exp_result = (exp_hits >= 4'(`WIN_HITS)) ? game_pkg::RES_WIN
                                                              : game_pkg::RES_LOSE;
                end else begin
                    exp_frames++;
                end
            end
            started = 1'b1;
            if (start && exp_state != game_pkg::ST_PLAY)
                exp_pend = 1'b1;                    // latched till the next edge
            if (hit && exp_state == game_pkg::ST_PLAY && exp_hits != 4'hf)
                exp_hits = exp_hits + 4'd1;
            if (exp_h == H_LAST) begin
                exp_h = '0;
                exp_v = (exp_v == V_LAST) ? '0 : exp_v + 11'd1;
            end else begin
                exp_h = exp_h + 11'd1;
            end
        end
        if (state !== exp_state || result !== exp_result) begin
            err_state++;
            $display("[ERROR] %s state/result expected %0d/%0d actual %0d/%0d",
                     test_name, exp_state, exp_result, state, result);
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT) begin
            $display("timeout after %0d cycles, the test sequence never finished", cycle_cnt);
            $display("Simulation FAILED");
            $finish;
        end
    end

    task automatic wait_edges(input int n);
        int target;
        target = edge_count + n;
        while (edge_count < target)
            @(posedge clk);
        #1;
    endtask

    task automatic send_hits(input int n);
        int gap;
        for (int i = 0; i < n; i++) begin
            lcg_state = lcg_next(lcg_state);
            gap = 20 + int'(lcg_state[23:16]);      // 20..275 cycles apart
            repeat (gap) @(posedge clk);
            #1 hit = 1'b1;
            @(posedge clk);
            #1 hit = 1'b0;
        end
    endtask

    task automatic press_start();
        @(posedge clk);
        #1 start = 1'b1;
        repeat (3) @(posedge clk);
        #1 start = 1'b0;
    endtask

    task automatic check_flow(input game_pkg::game_state_t s,
                              input game_pkg::game_result_t r);
        @(negedge clk);
        if (state !== s || result !== r) begin
            err_flow++;
            $display("[ERROR] %s state/result expected %0d/%0d actual %0d/%0d",
                     test_name, s, r, state, result);
        end
    endtask

    task automatic check_centre(input vga_pkg::rgb_t want);
        @(negedge clk);
        while (hcount != H_MID || vcount != V_MID)
            @(negedge clk);
        if (rgb !== want) begin
            err_flow++;
            $display("[ERROR] %s centre pixel expected %h actual %h", test_name, want, rgb);
        end
    endtask

    initial begin
        rst   = 1'b1;
        start = 1'b0;
        hit   = 1'b0;
        repeat (5) @(posedge clk);
        #1 rst = 1'b0;
        test_name = "start_screen";
        wait_edges(2);                              // two whole frames in ST_START
        check_centre(`RGB_FILL);
        send_hits(3);                               // ignored before play
        test_name = "win_round";
        press_start();
        wait_edges(1);
        check_flow(game_pkg::ST_PLAY, game_pkg::RES_NONE);
        send_hits(`WIN_HITS + 2);
        wait_edges(`ROUND_FRAMES);
        check_flow(game_pkg::ST_END, game_pkg::RES_WIN);
        check_centre(`RGB_WIN);
        test_name = "lose_round";
        send_hits(2);                               // would make a win if counted
        press_start();
        wait_edges(1);
        check_flow(game_pkg::ST_PLAY, game_pkg::RES_NONE);
        send_hits(`WIN_HITS - 1);
        wait_edges(`ROUND_FRAMES - 1);
        check_flow(game_pkg::ST_PLAY, game_pkg::RES_NONE);
        wait_edges(1);
        check_flow(game_pkg::ST_END, game_pkg::RES_LOSE);
        check_centre(`RGB_LOSE);
        wait_edges(1);                              // full frame past the change
        $display("errors: raster %0d, colour %0d, state %0d, flow %0d",
                 err_raster, err_rgb, err_state, err_flow);
        if (err_raster + err_rgb + err_state + err_flow == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire
